// ==== hw/lsu_cfg.svh ====
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// Address window that the memory controller serves with INCR bursts
`define LSU_SDRAM_BASE 32'hA000_0000
`define LSU_SDRAM_END  32'hBFFF_FFFF

// Fixed transaction ID for every AR and AW
`define LSU_AXI_ID 4'h0

// Cycles of bus wait before a transaction is abandoned
`define LSU_WDOG_LIMIT 64

`endif

// ==== hw/lsu_pkg.sv ====
package lsu_pkg;

    typedef enum logic [3:0] {
        LB  = 4'h0,
        LH  = 4'h1,
        LW  = 4'h2,
        LBU = 4'h3,
        LHU = 4'h4,
        SB  = 4'h5,
        SH  = 4'h6,
        SW  = 4'h7,
        NOP = 4'hf
    } mem_op_e;

    typedef enum logic [1:0] {
        FAULT_NONE     = 2'd0,
        FAULT_BUS      = 2'd1, // Slave answered with a nonzero BRESP or RRESP
        FAULT_MISALIGN = 2'd2,
        FAULT_TIMEOUT  = 2'd3
    } fault_e;

    typedef enum logic [2:0] {
        S_IDLE = 3'd0,
        S_AR   = 3'd1,
        S_R    = 3'd2,
        S_AW_W = 3'd3,
        S_B    = 3'd4,
        S_RSP  = 3'd5
    } lsu_state_e;

    localparam logic [1:0] AXI_BURST_FIXED = 2'b00;
    localparam logic [1:0] AXI_BURST_INCR  = 2'b01;

    typedef struct packed {
        mem_op_e     op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [4:0]  tag;
    } lsu_req_t;

    typedef struct packed {
        logic [4:0]  tag;
        logic [31:0] rdata;
        fault_e      fault;
    } lsu_rsp_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  id;
        logic [7:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
    } axi_a_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } axi_w_t;

    typedef struct packed {
        logic [1:0] resp;
        logic [3:0] id;
    } axi_b_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
        logic        last;
        logic [3:0]  id;
    } axi_r_t;

endpackage

// ==== hw/lsu_watchdog.sv ====
`include "lsu_cfg.svh"

module lsu_watchdog (
    input  logic clk,
    input  logic rst,
    input  logic run,
    output logic expired
);

    localparam int LIMIT = `LSU_WDOG_LIMIT;
    localparam int CNT_W = $clog2(LIMIT + 1);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (!run) begin
            cnt <= '0; // Every new bus wait starts from zero
        end else if (cnt != CNT_W'(LIMIT)) begin
            cnt <= cnt + 1'b1;
        end
    end

    assign expired = (cnt == CNT_W'(LIMIT));

endmodule

// ==== hw/store_align.sv ====
module store_align import lsu_pkg::*; (
    input  lsu_req_t   req,
    output axi_w_t     w,
    output logic [2:0] size
);

    logic [1:0] offset;
    logic [4:0] shamt;

    assign offset = req.addr[1:0];
    assign shamt  = {offset, 3'b000};

    always_comb begin
        w.last = 1'b1; // Single beat, so the only beat is the last
        case (req.op)
            SB: begin
                w.data = {24'b0, req.wdata[7:0]} << shamt;
                w.strb = 4'b0001 << offset;
                size   = 3'd0;
            end
            SH: begin
                w.data = {16'b0, req.wdata[15:0]} << shamt;
                w.strb = 4'b0011 << offset;
                size   = 3'd1;
            end
            SW: begin
                w.data = req.wdata;
                w.strb = 4'b1111;
                size   = 3'd2;
            end
            default: begin
                w.data = '0;
                w.strb = 4'b0000; // Loads and NOP never write a lane
                size   = 3'd2;
            end
        endcase
    end

endmodule

// ==== hw/load_extract.sv ====
module load_extract import lsu_pkg::*; (
    input  mem_op_e     op,
    input  logic [1:0]  offset,
    input  logic [31:0] raw,
    output logic [31:0] data
);

    logic [31:0] shifted;

    // The addressed byte lands in lane 0
    assign shifted = raw >> {offset, 3'b000};

    always_comb begin
        case (op)
            LB: begin
                data = {{24{shifted[7]}}, shifted[7:0]};
            end
            LBU: begin
                data = {24'b0, shifted[7:0]};
            end
            LH: begin
                data = {{16{shifted[15]}}, shifted[15:0]};
            end
            LHU: begin
                data = {16'b0, shifted[15:0]};
            end
            default: begin
                data = shifted;
            end
        endcase
    end

endmodule

// ==== hw/lsu_ctrl.sv ====
`include "lsu_cfg.svh"

module lsu_ctrl import lsu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        req_valid,
    output logic        req_ready,
    input  lsu_req_t    req,
    output logic        rsp_valid,
    input  logic        rsp_ready,
    output lsu_rsp_t    rsp,
    output logic        ar_valid,
    input  logic        ar_ready,
    output axi_a_t      ar,
    input  logic        r_valid,
    output logic        r_ready,
    input  axi_r_t      r,
    output logic        aw_valid,
    input  logic        aw_ready,
    output axi_a_t      aw,
    output logic        w_valid,
    input  logic        w_ready,
    output axi_w_t      w,
    input  logic        b_valid,
    output logic        b_ready,
    input  axi_b_t      b,
    input  logic [2:0]  st_size,
    input  axi_w_t      st_w,
    input  logic [31:0] ld_data,
    output lsu_req_t    cur_req,
    output logic        wdog_run,
    input  logic        wdog_expired
);

    lsu_state_e  state, state_d;
    lsu_req_t    req_q;
    fault_e      fault_q, fault_d;
    logic [31:0] rdata_q, rdata_d;
    logic        rsp_load;
    logic        aw_done, w_done, aw_done_d, w_done_d;
    logic        bus_dead; // Set by a timeout, cleared only by reset
    logic [1:0]  burst;
    logic [2:0]  ld_size;

    function automatic logic is_load(mem_op_e op);
        return op inside {LB, LH, LW, LBU, LHU};
    endfunction

    function automatic logic misaligned(lsu_req_t q);
        logic half, word;
        half = q.op inside {LH, LHU, SH};
        word = q.op inside {LW, SW};
        return (half && q.addr[0]) || (word && (q.addr[1:0] != 2'b00));
    endfunction

    assign burst = (req_q.addr >= `LSU_SDRAM_BASE && req_q.addr <= `LSU_SDRAM_END) ?
                   AXI_BURST_INCR : AXI_BURST_FIXED;

    always_comb begin
        case (req_q.op)
            LB, LBU: ld_size = 3'd0;
            LH, LHU: ld_size = 3'd1;
            default: ld_size = 3'd2;
        endcase
    end

    assign ar = '{addr: req_q.addr, id: `LSU_AXI_ID, len: 8'd0, size: ld_size, burst: burst};
    assign aw = '{addr: req_q.addr, id: `LSU_AXI_ID, len: 8'd0, size: st_size, burst: burst};
    assign w  = st_w;

    assign ar_valid  = (state == S_AR);
    assign r_ready   = (state == S_R);
    assign aw_valid  = (state == S_AW_W) && !aw_done;
    assign w_valid   = (state == S_AW_W) && !w_done;
    assign b_ready   = (state == S_B);
    assign rsp_valid = (state == S_RSP);
    assign wdog_run  = state inside {S_AR, S_R, S_AW_W, S_B};

    assign aw_done_d = aw_done || (aw_valid && aw_ready);
    assign w_done_d  = w_done || (w_valid && w_ready);

    always_comb begin
        state_d  = state;
        rsp_load = 1'b0;
        fault_d  = FAULT_NONE;
        rdata_d  = '0;
        case (state)
            S_IDLE: begin
                if (req_valid && req_ready) begin
                    if (req.op == NOP) begin
                        state_d  = S_RSP;
                        rsp_load = 1'b1;
                    end else if (misaligned(req)) begin
                        state_d  = S_RSP;
                        rsp_load = 1'b1;
                        fault_d  = FAULT_MISALIGN;
                    end else if (bus_dead) begin
                        state_d  = S_RSP; // Slave stopped answering earlier
                        rsp_load = 1'b1;
                        fault_d  = FAULT_TIMEOUT;
                    end else if (is_load(req.op)) begin
                        state_d = S_AR;
                    end else begin
                        state_d = S_AW_W;
                    end
                end
            end
            S_AR: begin
                if (ar_ready) begin
                    state_d = S_R;
                end
            end
            S_R: begin
                if (r_valid) begin
                    state_d  = S_RSP;
                    rsp_load = 1'b1;
                    fault_d  = (r.resp != 2'b00) ? FAULT_BUS : FAULT_NONE;
                    rdata_d  = (r.resp != 2'b00) ? 32'b0 : ld_data;
                end
            end
            S_AW_W: begin
                if (aw_done_d && w_done_d) begin
                    state_d = S_B; // The two channels may finish in either order
                end
            end
            S_B: begin
                if (b_valid) begin
                    state_d  = S_RSP;
                    rsp_load = 1'b1;
                    fault_d  = (b.resp != 2'b00) ? FAULT_BUS : FAULT_NONE;
                end
            end
            S_RSP: begin
                if (rsp_ready) begin
                    state_d = S_IDLE;
                end
            end
            default: begin
                state_d = S_IDLE;
            end
        endcase
        if (wdog_run && wdog_expired) begin
            state_d  = S_RSP; // Drops every valid and ready at once
            rsp_load = 1'b1;
            fault_d  = FAULT_TIMEOUT;
            rdata_d  = '0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= S_IDLE;
            req_ready <= 1'b0;
            aw_done   <= 1'b0;
            w_done    <= 1'b0;
            bus_dead  <= 1'b0;
        end else begin
            state     <= state_d;
            req_ready <= (state_d == S_IDLE);
            aw_done   <= (state == S_IDLE) ? 1'b0 : aw_done_d;
            w_done    <= (state == S_IDLE) ? 1'b0 : w_done_d;
            if (wdog_run && wdog_expired) begin
                bus_dead <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            req_q <= req;
        end
        if (rsp_load) begin
            fault_q <= fault_d;
            rdata_q <= rdata_d;
        end
    end

    assign rsp     = '{tag: req_q.tag, rdata: rdata_q, fault: fault_q};
    assign cur_req = req_q;

endmodule

// ==== hw/lsu_top.sv ====
module lsu_top import lsu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     req_valid,
    output logic     req_ready,
    input  lsu_req_t req,
    output logic     rsp_valid,
    input  logic     rsp_ready,
    output lsu_rsp_t rsp,
    output logic     ar_valid,
    input  logic     ar_ready,
    output axi_a_t   ar,
    input  logic     r_valid,
    output logic     r_ready,
    input  axi_r_t   r,
    output logic     aw_valid,
    input  logic     aw_ready,
    output axi_a_t   aw,
    output logic     w_valid,
    input  logic     w_ready,
    output axi_w_t   w,
    input  logic     b_valid,
    output logic     b_ready,
    input  axi_b_t   b
);

    lsu_req_t    cur_req;
    axi_w_t      st_w;
    logic [2:0]  st_size;
    logic [31:0] ld_data;
    logic        wdog_run;
    logic        wdog_expired;

    lsu_ctrl lsu_ctrl_inst (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req          (req),
        .rsp_valid    (rsp_valid),
        .rsp_ready    (rsp_ready),
        .rsp          (rsp),
        .ar_valid     (ar_valid),
        .ar_ready     (ar_ready),
        .ar           (ar),
        .r_valid      (r_valid),
        .r_ready      (r_ready),
        .r            (r),
        .aw_valid     (aw_valid),
        .aw_ready     (aw_ready),
        .aw           (aw),
        .w_valid      (w_valid),
        .w_ready      (w_ready),
        .w            (w),
        .b_valid      (b_valid),
        .b_ready      (b_ready),
        .b            (b),
        .st_size      (st_size),
        .st_w         (st_w),
        .ld_data      (ld_data),
        .cur_req      (cur_req),
        .wdog_run     (wdog_run),
        .wdog_expired (wdog_expired)
    );

    lsu_watchdog lsu_watchdog_inst (
        .clk     (clk),
        .rst     (rst),
        .run     (wdog_run),
        .expired (wdog_expired)
    );

    store_align store_align_inst (
        .req  (cur_req),
        .w    (st_w),
        .size (st_size)
    );

    // Read data goes straight from the R channel into the extractor
    load_extract load_extract_inst (
        .op     (cur_req.op),
        .offset (cur_req.addr[1:0]),
        .raw    (r.data),
        .data   (ld_data)
    );

endmodule

// ==== sim/axi_mem_model.sv ====
module axi_mem_model import lsu_pkg::*; #(
    parameter logic [3:0] ERR_REGION  = 4'h4,
    parameter logic [3:0] MUTE_REGION = 4'h5,
    parameter int         SEED        = 32'hf2ca_cf63
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   ar_valid,
    output logic   ar_ready,
    input  axi_a_t ar,
    output logic   r_valid,
    input  logic   r_ready,
    output axi_r_t r,
    input  logic   aw_valid,
    output logic   aw_ready,
    input  axi_a_t aw,
    input  logic   w_valid,
    output logic   w_ready,
    input  axi_w_t w,
    output logic   b_valid,
    input  logic   b_ready,
    output axi_b_t b
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [7:0] mem [0:1023];
    integer     seed;
    axi_a_t     ra;
    axi_a_t     wa;
    axi_w_t     wd;
    logic [9:0] rbase;
    int         aw_wait;
    int         w_wait;
    int         k;

    function automatic int delay();
        return $unsigned($random(seed)) % 4; // 0 to 3 wait cycles
    endfunction

    initial begin
        seed = SEED;
        for (int i = 0; i < 1024; i++) begin
            mem[i] = 8'h00;
        end
    end

    // The read side takes AR and then answers on R
    initial begin
        ar_ready = 1'b0;
        r_valid  = 1'b0;
        r        = '0;
        forever begin
            @(negedge clk);
            if (!rst && ar_valid && ar.addr[31:28] != MUTE_REGION) begin
                ra = ar;
                repeat (delay()) @(negedge clk);
                ar_ready = 1'b1;
                @(negedge clk);
                ar_ready = 1'b0;
                repeat (delay()) @(negedge clk);
                rbase  = {ra.addr[9:2], 2'b00};
                r.data = {mem[rbase + 10'd3], mem[rbase + 10'd2],
                          mem[rbase + 10'd1], mem[rbase]};
                r.resp = (ra.addr[31:28] == ERR_REGION) ? 2'b10 : 2'b00;
                r.last = 1'b1;
                r.id   = ra.id;
                r_valid = 1'b1;
                while (!r_ready) @(negedge clk);
                @(negedge clk);
                r_valid = 1'b0;
            end
        end
    end

    // The write side lets AW and W finish independently and then answers on B
    initial begin
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        b_valid  = 1'b0;
        b        = '0;
        forever begin
            @(negedge clk);
            if (!rst && aw_valid && aw.addr[31:28] != MUTE_REGION) begin
                wa      = aw;
                aw_wait = delay();
                w_wait  = delay();
                for (k = 0; k < 4; k++) begin
                    aw_ready = (k == aw_wait);
                    w_ready  = (k == w_wait);
                    if (k == w_wait) begin
                        wd = w;
                    end
                    @(negedge clk);
                end
                aw_ready = 1'b0;
                w_ready  = 1'b0;
                if (wa.addr[31:28] != ERR_REGION) begin
                    for (int j = 0; j < 4; j++) begin
                        if (wd.strb[j]) begin
                            mem[{wa.addr[9:2], 2'(j)}] = wd.data[8*j +: 8];
                        end
                    end
                end
                repeat (delay()) @(negedge clk);
                b.resp  = (wa.addr[31:28] == ERR_REGION) ? 2'b10 : 2'b00;
                b.id    = wa.id;
                b_valid = 1'b1;
                while (!b_ready) @(negedge clk);
                @(negedge clk);
                b_valid = 1'b0;
            end
        end
    end

endmodule

// ==== sim/tb_lsu_top.sv ====
`include "lsu_cfg.svh"

module tb_lsu_top import lsu_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [3:0] ERR_REGION  = 4'h4;
    localparam logic [3:0] MUTE_REGION = 4'h5;
    localparam int         N_REQ       = 80;
    localparam int         MAX_CYCLES  = 200 * N_REQ;

    logic     clk;
    logic     rst;
    logic     req_valid;
    logic     req_ready;
    lsu_req_t req;
    logic     rsp_valid;
    logic     rsp_ready;
    lsu_rsp_t rsp;
    logic     ar_valid, ar_ready, r_valid, r_ready;
    logic     aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
    axi_a_t   ar, aw;
    axi_r_t   r;
    axi_w_t   w;
    axi_b_t   b;

    integer     seed;
    logic [7:0] shadow [0:1023];
    lsu_rsp_t   exp_rsp_q [$];
    axi_a_t     exp_ar_q [$];
    axi_a_t     exp_aw_q [$];
    logic [3:0] exp_strb_q [$];
    int         errors;
    int         err_mark;
    int         tests_failed;
    int         tests_run;
    int         bus_valids;
    int         cycles;
    logic [4:0] next_tag;

    lsu_top lsu_top_inst (.*);

    axi_mem_model #(.ERR_REGION(ERR_REGION), .MUTE_REGION(MUTE_REGION)) mem_inst (.*);

    always #4 clk = ~clk;

    task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("error %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    function automatic int op_bytes(mem_op_e op);
        if (op inside {LB, LBU, SB}) return 1;
        if (op inside {LH, LHU, SH}) return 2;
        return 4;
    endfunction

    function automatic logic misaligned(lsu_req_t q);
        return (q.op != NOP) && ((q.addr % op_bytes(q.op)) != 0);
    endfunction

    // Expected response from the opcode, the address region and the shadow memory
    function automatic lsu_rsp_t ref_rsp(lsu_req_t q);
        lsu_rsp_t   e;
        logic [9:0] a;
        logic [7:0] b0, b1;
        e.tag   = q.tag;
        e.rdata = '0;
        e.fault = FAULT_NONE;
        a  = q.addr[9:0];
        b0 = shadow[a];
        b1 = shadow[a + 10'd1];
        if (q.op == NOP) begin
            e.fault = FAULT_NONE;
        end else if (misaligned(q)) begin
            e.fault = FAULT_MISALIGN;
        end else if (q.addr[31:28] == MUTE_REGION) begin
            e.fault = FAULT_TIMEOUT;
        end else if (q.addr[31:28] == ERR_REGION) begin
            e.fault = FAULT_BUS;
        end else if (q.op == LB) begin
            e.rdata = {{24{b0[7]}}, b0};
        end else if (q.op == LBU) begin
            e.rdata = {24'h0, b0};
        end else if (q.op == LH) begin
            e.rdata = {{16{b1[7]}}, b1, b0};
        end else if (q.op == LHU) begin
            e.rdata = {16'h0, b1, b0};
        end else if (q.op == LW) begin
            e.rdata = {shadow[a + 10'd3], shadow[a + 10'd2], b1, b0};
        end
        return e;
    endfunction

    function automatic axi_a_t ref_addr(lsu_req_t q);
        axi_a_t ea;
        int     n;
        n        = op_bytes(q.op);
        ea.addr  = q.addr;
        ea.id    = `LSU_AXI_ID;
        ea.len   = 8'd0;
        ea.size  = (n == 1) ? 3'd0 : (n == 2) ? 3'd1 : 3'd2;
        ea.burst = (q.addr >= `LSU_SDRAM_BASE && q.addr <= `LSU_SDRAM_END) ? 2'b01 : 2'b00;
        return ea;
    endfunction

    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    task automatic issue(input mem_op_e op, input logic [31:0] addr, input logic [31:0] wdata);
        lsu_req_t q;
        int       n;
        q  = '{op: op, addr: addr, wdata: wdata, tag: next_tag};
        n  = op_bytes(op);
        next_tag++;
        exp_rsp_q.push_back(ref_rsp(q));
        if (op != NOP && !misaligned(q)) begin
            if (op inside {SB, SH, SW}) begin
                exp_aw_q.push_back(ref_addr(q));
                exp_strb_q.push_back(((n == 1) ? 4'b0001 : (n == 2) ? 4'b0011 : 4'b1111)
                                     << addr[1:0]);
                if (addr[31:28] != ERR_REGION && addr[31:28] != MUTE_REGION) begin
                    for (int i = 0; i < n; i++) begin
                        shadow[addr[9:0] + 10'(i)] = wdata[8*i +: 8];
                    end
                end
            end else begin
                exp_ar_q.push_back(ref_addr(q));
            end
        end
        req       = q;
        req_valid = 1'b1;
        while (!req_ready) @(negedge clk);
        @(negedge clk);
        req_valid = 1'b0;
        req       = '0;
    endtask

    task automatic wait_idle();
        while (exp_rsp_q.size() != 0) @(negedge clk);
        @(negedge clk);
    endtask

    task automatic finish_test(input string name);
        wait_idle();
        tests_run++;
        if (errors == err_mark) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - err_mark);
            tests_failed++;
        end
        err_mark = errors;
    endtask

    // Handshakes are sampled mid low phase, where every signal is settled
    always begin
        @(negedge clk);
        #2;
        if (!rst) begin
            if (ar_valid || aw_valid || w_valid) bus_valids++;
            if (ar_valid && ar_ready) begin
                if (exp_ar_q.size() == 0) begin
                    $display("Unexpected AR handshake at %0t", $time);
                    errors++;
                end else begin
                    check("AR payload", 64'(ar), 64'(exp_ar_q.pop_front()));
                end
            end
            if (aw_valid && aw_ready) begin
                if (exp_aw_q.size() == 0) begin
                    $display("Unexpected AW handshake at %0t", $time);
                    errors++;
                end else begin
                    check("AW payload", 64'(aw), 64'(exp_aw_q.pop_front()));
                end
            end
            if (w_valid && w_ready) begin
                if (exp_strb_q.size() == 0) begin
                    $display("Unexpected W handshake at %0t", $time);
                    errors++;
                end else begin
                    check("W strobe and last", 64'({w.strb, w.last}),
                          64'({exp_strb_q.pop_front(), 1'b1}));
                end
            end
            if (rsp_valid && rsp_ready) begin
                if (exp_rsp_q.size() == 0) begin
                    $display("Response arrived with none outstanding at %0t", $time);
                    errors++;
                end else begin
                    check("response", 64'(rsp), 64'(exp_rsp_q.pop_front()));
                end
            end
        end
    end

    always @(negedge clk) begin
        rsp_ready = (($random(seed) % 4) != 0); // Writeback stalls now and then
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        logic [31:0] bases [2];
        logic [31:0] base;
        logic [31:0] rword;
        int          mark;
        clk = 1'b0;
        rst = 1'b1;
        req_valid = 1'b0;
        req = '0;
        rsp_ready = 1'b0;
        seed = 32'hf2ca_cf63;
        errors = 0;
        err_mark = 0;
        tests_failed = 0;
        tests_run = 0;
        bus_valids = 0;
        cycles = 0;
        next_tag = '0;
        for (int i = 0; i < 1024; i++) begin
            shadow[i] = 8'h00;
        end
        bases[0] = 32'hA000_0100;
        bases[1] = 32'h0000_0200;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        // Every width and lane in both the SDRAM window and plain memory
        for (int g = 0; g < 2; g++) begin
            base = bases[g];
            issue(SW, base, rnd());
            for (int off = 0; off < 4; off++) issue(SB, base + 4 + off, rnd());
            for (int off = 0; off < 4; off += 2) issue(SH, base + 8 + off, rnd());
            for (int off = 0; off < 4; off++) begin
                issue(LB, base + off, 32'h0);
                issue(LBU, base + off, 32'h0);
            end
            for (int off = 0; off < 4; off += 2) begin
                issue(LH, base + 4 + off, 32'h0);
                issue(LHU, base + 4 + off, 32'h0);
            end
            issue(LW, base + 8, 32'h0);
        end
        finish_test("store_load_payload");

        mark = bus_valids;
        for (int off = 1; off < 4; off++) begin
            issue(LW, 32'h0000_0040 + off, 32'h0);
            issue(SW, 32'hA000_0040 + off, rnd());
        end
        for (int off = 1; off < 4; off += 2) begin
            issue(LH, 32'h0000_0050 + off, 32'h0);
            issue(LHU, 32'hA000_0050 + off, 32'h0);
            issue(SH, 32'h0000_0060 + off, rnd());
        end
        wait_idle();
        check("bus valids during misaligned accesses", 64'(bus_valids), 64'(mark));
        finish_test("misaligned");

        issue(SW, 32'h0000_0300, rnd());
        issue(SW, 32'h4000_0300, rnd());
        issue(SB, 32'h4000_0301, rnd());
        issue(LW, 32'h4000_0300, 32'h0);
        issue(LH, 32'h4000_0302, 32'h0);
        issue(LW, 32'h0000_0300, 32'h0); // Error stores must not have landed
        finish_test("bus_error");

        for (int i = 0; i < 20; i++) begin
            rword = rnd();
            base  = {22'h0, rword[9:2], 2'b00};
            case ($unsigned($random(seed)) % 3)
                0: issue(NOP, base, 32'h0);
                1: issue(SW, base, rnd());
                default: issue(LW, base | 32'hA000_0000, 32'h0);
            endcase
        end
        finish_test("order_backpressure");

        issue(LW, 32'h5000_0000, 32'h0);
        wait_idle();
        #2;
        check("AXI valids and readies after timeout",
              64'({ar_valid, r_ready, aw_valid, w_valid, b_ready}), 64'(0));
        finish_test("timeout");

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+hw
hw/lsu_pkg.sv
hw/lsu_watchdog.sv
hw/store_align.sv
hw/load_extract.sv
hw/lsu_ctrl.sv
hw/lsu_top.sv
sim/axi_mem_model.sv
sim/tb_lsu_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_lsu_top
BUILD_DIR ?= obj_dir
FILELIST  ?= files.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP BUILD_DIR FILELIST LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Result: PASSED" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
